// File: logic/fifo_mm_config.svh
`ifndef FIFO_MM_CONFIG_SVH
`define FIFO_MM_CONFIG_SVH

// FIFO geometry
`define FIFO_DATA_W        32
`define FIFO_DEPTH_LOG2    4      // 16 entries

// Status thresholds
`define FIFO_ALMOST_FULL   2      // Set when count >= depth - 2
`define FIFO_ALMOST_EMPTY  2      // Set when count is 1..2

// Bus address width and register map
`define AXIL_ADDR_W        4
`define REG_DATA           4'h0   // Write pushes, read pops
`define REG_STATUS         4'h4
`define REG_CONTROL        4'h8
`define REG_COUNT          4'hC

`endif

// File: logic/fifo_mm_pkg.sv
`include "fifo_mm_config.svh"

package fifo_mm_pkg;

    // AXI4-Lite response codes that this block returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // Register address as seen on the bus
    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;

    // STATUS register layout in bits 3 down to 0
    typedef struct packed {
        logic almost_full;
        logic almost_empty;
        logic full;
        logic empty;
    } fifo_status_t;

endpackage

// File: logic/axil_rr_arbiter.sv
`timescale 1ns/1ps
`include "fifo_mm_config.svh"

module axil_rr_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    // Port 0
    input  fifo_mm_pkg::axil_addr_t   s0_awaddr,
    input  logic                      s0_awvalid,
    output logic                      s0_awready,
    input  logic [`FIFO_DATA_W-1:0]   s0_wdata,
    input  logic                      s0_wvalid,
    output logic                      s0_wready,
    output fifo_mm_pkg::axil_resp_e   s0_bresp,
    output logic                      s0_bvalid,
    input  logic                      s0_bready,
    input  fifo_mm_pkg::axil_addr_t   s0_araddr,
    input  logic                      s0_arvalid,
    output logic                      s0_arready,
    output logic [`FIFO_DATA_W-1:0]   s0_rdata,
    output fifo_mm_pkg::axil_resp_e   s0_rresp,
    output logic                      s0_rvalid,
    input  logic                      s0_rready,
    // Port 1
    input  fifo_mm_pkg::axil_addr_t   s1_awaddr,
    input  logic                      s1_awvalid,
    output logic                      s1_awready,
    input  logic [`FIFO_DATA_W-1:0]   s1_wdata,
    input  logic                      s1_wvalid,
    output logic                      s1_wready,
    output fifo_mm_pkg::axil_resp_e   s1_bresp,
    output logic                      s1_bvalid,
    input  logic                      s1_bready,
    input  fifo_mm_pkg::axil_addr_t   s1_araddr,
    input  logic                      s1_arvalid,
    output logic                      s1_arready,
    output logic [`FIFO_DATA_W-1:0]   s1_rdata,
    output fifo_mm_pkg::axil_resp_e   s1_rresp,
    output logic                      s1_rvalid,
    input  logic                      s1_rready,
    // Shared slave
    output fifo_mm_pkg::axil_addr_t   m_awaddr,
    output logic                      m_awvalid,
    input  logic                      m_awready,
    output logic [`FIFO_DATA_W-1:0]   m_wdata,
    output logic                      m_wvalid,
    input  logic                      m_wready,
    input  fifo_mm_pkg::axil_resp_e   m_bresp,
    input  logic                      m_bvalid,
    output logic                      m_bready,
    output fifo_mm_pkg::axil_addr_t   m_araddr,
    output logic                      m_arvalid,
    input  logic                      m_arready,
    input  logic [`FIFO_DATA_W-1:0]   m_rdata,
    input  fifo_mm_pkg::axil_resp_e   m_rresp,
    input  logic                      m_rvalid,
    output logic                      m_rready
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GNT0,
        ARB_GNT1
    } arb_state_e;

    arb_state_e state;
    logic       last_gnt;   // High when port 1 held the last grant
    logic       gnt_wr;     // Locked transaction is a write
    logic       req0_wr;
    logic       req1_wr;
    logic       req0;
    logic       req1;
    logic       sel1;
    logic       wr0;
    logic       wr1;
    logic       rd0;
    logic       rd1;
    logic       done;

    assign req0_wr = s0_awvalid & s0_wvalid;
    assign req1_wr = s1_awvalid & s1_wvalid;
    assign req0    = req0_wr | s0_arvalid;
    assign req1    = req1_wr | s1_arvalid;

    // Per-port, per-direction channel enables while a grant is held
    assign sel1 = (state == ARB_GNT1);
    assign wr0  = (state == ARB_GNT0) & gnt_wr;
    assign rd0  = (state == ARB_GNT0) & ~gnt_wr;
    assign wr1  = sel1 & gnt_wr;
    assign rd1  = sel1 & ~gnt_wr;

    assign done = (m_bvalid & m_bready) | (m_rvalid & m_rready);  // Response handshake

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ARB_IDLE;
            last_gnt <= 1'b0;       // Port 0 counts as last, so port 1 wins a first tie
            gnt_wr   <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (req0 && (!req1 || last_gnt)) begin
                        state    <= ARB_GNT0;
                        last_gnt <= 1'b0;
                        gnt_wr   <= req0_wr;    // Write wins if both kinds are pending
                    end else if (req1) begin
                        state    <= ARB_GNT1;
                        last_gnt <= 1'b1;
                        gnt_wr   <= req1_wr;
                    end
                end
                default: begin
                    if (done) begin
                        state <= ARB_IDLE;
                    end
                end
            endcase
        end
    end

    // Requests toward the shared slave
    assign m_awaddr  = sel1 ? s1_awaddr : s0_awaddr;
    assign m_wdata   = sel1 ? s1_wdata : s0_wdata;
    assign m_araddr  = sel1 ? s1_araddr : s0_araddr;
    assign m_awvalid = (wr0 & s0_awvalid) | (wr1 & s1_awvalid);
    assign m_wvalid  = (wr0 & s0_wvalid) | (wr1 & s1_wvalid);
    assign m_bready  = (wr0 & s0_bready) | (wr1 & s1_bready);
    assign m_arvalid = (rd0 & s0_arvalid) | (rd1 & s1_arvalid);
    assign m_rready  = (rd0 & s0_rready) | (rd1 & s1_rready);

    // Handshakes back to the granted port only
    assign s0_awready = wr0 & m_awready;
    assign s0_wready  = wr0 & m_wready;
    assign s0_bvalid  = wr0 & m_bvalid;
    assign s0_arready = rd0 & m_arready;
    assign s0_rvalid  = rd0 & m_rvalid;
    assign s1_awready = wr1 & m_awready;
    assign s1_wready  = wr1 & m_wready;
    assign s1_bvalid  = wr1 & m_bvalid;
    assign s1_arready = rd1 & m_arready;
    assign s1_rvalid  = rd1 & m_rvalid;

    // Response payloads are shared, qualified by the valids above
    assign s0_bresp = m_bresp;
    assign s1_bresp = m_bresp;
    assign s0_rdata = m_rdata;
    assign s1_rdata = m_rdata;
    assign s0_rresp = m_rresp;
    assign s1_rresp = m_rresp;

endmodule

// File: logic/fifo_store.sv
`timescale 1ns/1ps
`include "fifo_mm_config.svh"

module fifo_store #(
    parameter int DATA_W     = `FIFO_DATA_W,
    parameter int DEPTH_LOG2 = `FIFO_DEPTH_LOG2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  logic [DATA_W-1:0]     push_data,
    input  logic                  pop,
    input  logic                  flush,
    output logic [DATA_W-1:0]     head_data,
    output logic [DEPTH_LOG2:0]   count,
    output logic                  empty,
    output logic                  full
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [DATA_W-1:0]   mem [DEPTH];
    logic [DEPTH_LOG2:0] wr_ptr;    // Extra MSB marks the wrap
    logic [DEPTH_LOG2:0] rd_ptr;
    logic                do_push;
    logic                do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign count = wr_ptr - rd_ptr;
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                   (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;           // Flush beats push and pop
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= push_data;
        end
    end

    // First word falls through
    assign head_data = mem[rd_ptr[DEPTH_LOG2-1:0]];

endmodule

// File: logic/fifo_csr.sv
`timescale 1ns/1ps
`include "fifo_mm_config.svh"

module fifo_csr (
    input  logic                        clk,
    input  logic                        rst_n,
    // AXI4-Lite slave
    input  fifo_mm_pkg::axil_addr_t     awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`FIFO_DATA_W-1:0]     wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output fifo_mm_pkg::axil_resp_e     bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  fifo_mm_pkg::axil_addr_t     araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`FIFO_DATA_W-1:0]     rdata,
    output fifo_mm_pkg::axil_resp_e     rresp,
    output logic                        rvalid,
    input  logic                        rready,
    // Stream side
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [`FIFO_DATA_W-1:0]     in_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [`FIFO_DATA_W-1:0]     out_data,
    // Storage side
    output logic                        push,
    output logic [`FIFO_DATA_W-1:0]     push_data,
    output logic                        pop,
    output logic                        flush,
    input  logic [`FIFO_DATA_W-1:0]     head_data,
    input  logic [`FIFO_DEPTH_LOG2:0]   count,
    input  logic                        empty,
    input  logic                        full
);

    import fifo_mm_pkg::*;

    localparam int DEPTH = 1 << `FIFO_DEPTH_LOG2;
    localparam int CNT_W = `FIFO_DEPTH_LOG2 + 1;

    logic                    wr_accept;
    logic                    rd_accept;
    logic                    wr_is_data;
    logic                    wr_is_ctrl;
    logic                    rd_is_data;
    logic                    bus_push;
    logic                    bus_pop;
    fifo_status_t            status;
    axil_resp_e              wr_code;
    axil_resp_e              rd_code;
    logic [`FIFO_DATA_W-1:0] rd_value;

    // One outstanding response per direction
    assign wr_accept = awvalid & wvalid & ~bvalid;
    assign rd_accept = arvalid & ~rvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign arready   = rd_accept;

    assign wr_is_data = (awaddr == `REG_DATA);
    assign wr_is_ctrl = (awaddr == `REG_CONTROL);
    assign rd_is_data = (araddr == `REG_DATA);

    assign bus_push = wr_accept & wr_is_data & ~full;
    assign bus_pop  = rd_accept & rd_is_data & ~empty;
    assign flush    = wr_accept & wr_is_ctrl & wdata[0];

    // Bus has priority over the stream ports
    assign in_ready  = ~full & ~bus_push & ~flush;
    assign out_valid = ~empty & ~bus_pop & ~flush;
    assign out_data  = head_data;

    assign push      = bus_push | (in_valid & in_ready);
    assign push_data = bus_push ? wdata : in_data;
    assign pop       = bus_pop | (out_valid & out_ready);

    always_comb begin
        status.empty        = empty;
        status.full         = full;
        status.almost_empty = (count != '0) && (count <= CNT_W'(`FIFO_ALMOST_EMPTY));
        status.almost_full  = (count >= CNT_W'(DEPTH - `FIFO_ALMOST_FULL));
    end

    always_comb begin
        if (wr_is_data) begin
            wr_code = full ? SLVERR : OKAY;     // Push into a full FIFO is dropped
        end else if (wr_is_ctrl) begin
            wr_code = OKAY;
        end else begin
            wr_code = SLVERR;                   // STATUS, COUNT and holes are read-only
        end
    end

    always_comb begin
        rd_value = '0;
        rd_code  = OKAY;
        case (araddr)
            `REG_DATA: begin
                if (empty) begin
                    rd_code = SLVERR;
                end else begin
                    rd_value = head_data;
                end
            end
            `REG_STATUS:  rd_value = {{(`FIFO_DATA_W-4){1'b0}}, status};
            `REG_CONTROL: rd_value = '0;        // Flush bit is self-clearing
            `REG_COUNT:   rd_value = {{(`FIFO_DATA_W-CNT_W){1'b0}}, count};
            default:      rd_code  = SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (wr_accept) begin
                bvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (rd_accept) begin
                rvalid <= 1'b1;
            end
        end
    end

    // Response payload captured with the request
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_code;
        end
        if (rd_accept) begin
            rdata <= rd_value;
            rresp <= rd_code;
        end
    end

endmodule

// File: logic/fifo_mm_top.sv
`timescale 1ns/1ps
`include "fifo_mm_config.svh"

module fifo_mm_top (
    input  logic                      clk,
    input  logic                      rst_n,
    // Bus port 0
    input  fifo_mm_pkg::axil_addr_t   s0_awaddr,
    input  logic                      s0_awvalid,
    output logic                      s0_awready,
    input  logic [`FIFO_DATA_W-1:0]   s0_wdata,
    input  logic                      s0_wvalid,
    output logic                      s0_wready,
    output fifo_mm_pkg::axil_resp_e   s0_bresp,
    output logic                      s0_bvalid,
    input  logic                      s0_bready,
    input  fifo_mm_pkg::axil_addr_t   s0_araddr,
    input  logic                      s0_arvalid,
    output logic                      s0_arready,
    output logic [`FIFO_DATA_W-1:0]   s0_rdata,
    output fifo_mm_pkg::axil_resp_e   s0_rresp,
    output logic                      s0_rvalid,
    input  logic                      s0_rready,
    // Bus port 1
    input  fifo_mm_pkg::axil_addr_t   s1_awaddr,
    input  logic                      s1_awvalid,
    output logic                      s1_awready,
    input  logic [`FIFO_DATA_W-1:0]   s1_wdata,
    input  logic                      s1_wvalid,
    output logic                      s1_wready,
    output fifo_mm_pkg::axil_resp_e   s1_bresp,
    output logic                      s1_bvalid,
    input  logic                      s1_bready,
    input  fifo_mm_pkg::axil_addr_t   s1_araddr,
    input  logic                      s1_arvalid,
    output logic                      s1_arready,
    output logic [`FIFO_DATA_W-1:0]   s1_rdata,
    output fifo_mm_pkg::axil_resp_e   s1_rresp,
    output logic                      s1_rvalid,
    input  logic                      s1_rready,
    // Streams
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [`FIFO_DATA_W-1:0]   in_data,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [`FIFO_DATA_W-1:0]   out_data
);

    import fifo_mm_pkg::*;

    // Arbitrated bus
    axil_addr_t                m_awaddr;
    logic                      m_awvalid;
    logic                      m_awready;
    logic [`FIFO_DATA_W-1:0]   m_wdata;
    logic                      m_wvalid;
    logic                      m_wready;
    axil_resp_e                m_bresp;
    logic                      m_bvalid;
    logic                      m_bready;
    axil_addr_t                m_araddr;
    logic                      m_arvalid;
    logic                      m_arready;
    logic [`FIFO_DATA_W-1:0]   m_rdata;
    axil_resp_e                m_rresp;
    logic                      m_rvalid;
    logic                      m_rready;

    // Storage controls and state
    logic                      push;
    logic [`FIFO_DATA_W-1:0]   push_data;
    logic                      pop;
    logic                      flush;
    logic [`FIFO_DATA_W-1:0]   head_data;
    logic [`FIFO_DEPTH_LOG2:0] count;
    logic                      empty;
    logic                      full;

    axil_rr_arbiter axil_rr_arbiter_i (.*);

    fifo_csr fifo_csr_i (
        .awaddr  (m_awaddr),
        .awvalid (m_awvalid),
        .awready (m_awready),
        .wdata   (m_wdata),
        .wvalid  (m_wvalid),
        .wready  (m_wready),
        .bresp   (m_bresp),
        .bvalid  (m_bvalid),
        .bready  (m_bready),
        .araddr  (m_araddr),
        .arvalid (m_arvalid),
        .arready (m_arready),
        .rdata   (m_rdata),
        .rresp   (m_rresp),
        .rvalid  (m_rvalid),
        .rready  (m_rready),
        .*                          // Clock, reset, streams and storage
    );

    fifo_store #(
        .DATA_W     (`FIFO_DATA_W),
        .DEPTH_LOG2 (`FIFO_DEPTH_LOG2)
    ) fifo_store_i (.*);

endmodule

// File: dv/fifo_mm_tb.sv
`timescale 1ns/1ps
`include "fifo_mm_config.svh"

module fifo_mm_tb;

    import fifo_mm_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int DEPTH         = 1 << `FIFO_DEPTH_LOG2;
    localparam int RAND_OPS      = 100;    // Operations per port in the random traffic test
    localparam int MIX_OPS       = 40;     // Operations per port alongside the streams
    localparam int STREAM_CYCLES = 300;
    localparam int OP_COUNT      = 2 * RAND_OPS + 2 * MIX_OPS + STREAM_CYCLES + 80;

    logic                          clk;
    logic                          rst_n;
    logic [1:0][`AXIL_ADDR_W-1:0]  awaddr;
    logic [1:0]                    awvalid;
    logic [1:0][`FIFO_DATA_W-1:0]  wdata;
    logic [1:0]                    wvalid;
    logic [1:0]                    bready;
    logic [1:0][`AXIL_ADDR_W-1:0]  araddr;
    logic [1:0]                    arvalid;
    logic [1:0]                    rready;
    wire  [1:0]                    awready;
    wire  [1:0]                    wready;
    wire  [1:0][1:0]               bresp;
    wire  [1:0]                    bvalid;
    wire  [1:0]                    arready;
    wire  [1:0][`FIFO_DATA_W-1:0]  rdata;
    wire  [1:0][1:0]               rresp;
    wire  [1:0]                    rvalid;
    logic                          in_valid;
    wire                           in_ready;
    logic [`FIFO_DATA_W-1:0]       in_data;
    wire                           out_valid;
    logic                          out_ready;
    wire  [`FIFO_DATA_W-1:0]       out_data;

    integer                  seed = 32'hc55e;
    logic [`FIFO_DATA_W-1:0] model [$];        // Reference FIFO contents
    logic [1:0]              exp_bresp [2];
    logic [1:0]              exp_rresp [2];
    logic [`FIFO_DATA_W-1:0] exp_rdata [2];
    int                      error_count = 0;
    int                      test_errors = 0;
    int                      tests_run = 0;
    int                      tests_failed = 0;

    fifo_mm_top fifo_mm_top_i (
        .clk(clk), .rst_n(rst_n),
        .s0_awaddr(awaddr[0]), .s0_awvalid(awvalid[0]), .s0_awready(awready[0]),
        .s0_wdata(wdata[0]), .s0_wvalid(wvalid[0]), .s0_wready(wready[0]),
        .s0_bresp(bresp[0]), .s0_bvalid(bvalid[0]), .s0_bready(bready[0]),
        .s0_araddr(araddr[0]), .s0_arvalid(arvalid[0]), .s0_arready(arready[0]),
        .s0_rdata(rdata[0]), .s0_rresp(rresp[0]), .s0_rvalid(rvalid[0]), .s0_rready(rready[0]),
        .s1_awaddr(awaddr[1]), .s1_awvalid(awvalid[1]), .s1_awready(awready[1]),
        .s1_wdata(wdata[1]), .s1_wvalid(wvalid[1]), .s1_wready(wready[1]),
        .s1_bresp(bresp[1]), .s1_bvalid(bvalid[1]), .s1_bready(bready[1]),
        .s1_araddr(araddr[1]), .s1_arvalid(arvalid[1]), .s1_arready(arready[1]),
        .s1_rdata(rdata[1]), .s1_rresp(rresp[1]), .s1_rvalid(rvalid[1]), .s1_rready(rready[1]),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(OP_COUNT * 20 * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", OP_COUNT * 20);
        $display("TEST FAIL");
        $finish;
    end

    task automatic report_error(input string msg);
        $display("[ERROR] %0d ns: %s", $time, msg);
        error_count++;
    endtask

    function automatic logic coin();
        return ($random(seed) & 1) != 0;
    endfunction

    // Status bits almost_full, almost_empty, full and empty from the threshold rules
    function automatic logic [3:0] expected_status(input int n);
        logic af;
        logic ae;
        af = n >= DEPTH - `FIFO_ALMOST_FULL;
        ae = (n >= 1) && (n <= `FIFO_ALMOST_EMPTY);
        return {af, ae, n == DEPTH, n == 0};
    endfunction

    // All bus tasks start and end just after a falling edge
    task automatic bus_write(input int p, input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        awaddr[p]  = addr;
        wdata[p]   = data;
        awvalid[p] = 1'b1;
        wvalid[p]  = 1'b1;
        @(posedge clk);
        while (!(awready[p] && wready[p])) @(posedge clk);
        @(negedge clk);
        awvalid[p] = 1'b0;
        wvalid[p]  = 1'b0;
        forever begin
            bready[p] = coin();             // Random back-pressure
            @(posedge clk);
            if (bvalid[p] && bready[p]) break;
            @(negedge clk);
        end
        resp = bresp[p];
        @(negedge clk);
        bready[p] = 1'b0;
    endtask

    task automatic bus_read(input int p, input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr[p]  = addr;
        arvalid[p] = 1'b1;
        @(posedge clk);
        while (!arready[p]) @(posedge clk);
        @(negedge clk);
        arvalid[p] = 1'b0;
        forever begin
            rready[p] = coin();
            @(posedge clk);
            if (rvalid[p] && rready[p]) break;
            @(negedge clk);
        end
        data = rdata[p];
        resp = rresp[p];
        @(negedge clk);
        rready[p] = 1'b0;
    endtask

    task automatic random_op(input int p);
        int          pick;
        logic [31:0] v;
        logic [1:0]  r;
        pick = $unsigned($random(seed)) % 8;
        if (pick < 4) begin
            bus_write(p, `REG_DATA, $random(seed), r);
        end else if (pick < 7) begin
            bus_read(p, `REG_DATA, v, r);
        end else begin
            bus_read(p, coin() ? `REG_STATUS : `REG_COUNT, v, r);
        end
    endtask

    // Stream producer and consumer that hold in_valid until accepted
    task automatic drive_stream(input int cycles);
        logic hs;
        for (int i = 0; i < cycles || in_valid; i++) begin
            @(posedge clk);
            hs = in_valid && in_ready;
            @(negedge clk);
            if (!in_valid || hs) begin
                in_valid = (i < cycles) && coin();
                in_data  = $random(seed);
            end
            out_ready = coin();
        end
        out_ready = 1'b0;
    endtask

    task automatic end_test(input string name);
        int n;
        n = error_count - test_errors;
        tests_run++;
        if (n != 0) tests_failed++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (n == 0) ? "passed" : "failed", n);
        test_errors = error_count;
    endtask

    // Model updates on the handshakes and predicts responses from the pre-edge state
    always @(posedge clk) begin
        int          sz;
        logic        do_pop;
        logic        do_push;
        logic        do_flush;
        logic [31:0] push_val;
        if (rst_n) begin
            sz       = model.size();
            do_pop   = 1'b0;
            do_push  = 1'b0;
            do_flush = 1'b0;
            push_val = '0;
            if (in_ready && sz == DEPTH) report_error("in_ready high while model is full");
            if (out_valid && sz == 0) report_error("out_valid high while model is empty");
            for (int p = 0; p < 2; p++) begin
                if (bvalid[p] && bready[p] && bresp[p] != exp_bresp[p])
                    report_error($sformatf("port %0d bresp %0d, expected %0d",
                                           p, bresp[p], exp_bresp[p]));
                if (rvalid[p] && rready[p] && (rresp[p] != exp_rresp[p] ||
                                               rdata[p] != exp_rdata[p]))
                    report_error($sformatf("port %0d read %h/%0d, expected %h/%0d", p,
                                           rdata[p], rresp[p], exp_rdata[p], exp_rresp[p]));
                if (awvalid[p] && awready[p] && wvalid[p] && wready[p]) begin
                    exp_bresp[p] = SLVERR;
                    if (awaddr[p] == `REG_DATA && sz < DEPTH) begin
                        exp_bresp[p] = OKAY;
                        do_push  = 1'b1;
                        push_val = wdata[p];
                    end else if (awaddr[p] == `REG_CONTROL) begin
                        exp_bresp[p] = OKAY;
                        do_flush = wdata[p][0];
                    end
                end
                if (arvalid[p] && arready[p]) begin
                    exp_rresp[p] = OKAY;
                    exp_rdata[p] = '0;
                    case (araddr[p])
                        `REG_DATA: begin
                            if (sz == 0) begin
                                exp_rresp[p] = SLVERR;
                            end else begin
                                exp_rdata[p] = model[0];
                                do_pop = 1'b1;
                            end
                        end
                        `REG_STATUS:  exp_rdata[p] = {28'd0, expected_status(sz)};
                        `REG_CONTROL: exp_rdata[p] = '0;
                        `REG_COUNT:   exp_rdata[p] = sz;
                        default:      exp_rresp[p] = SLVERR;
                    endcase
                end
            end
            if (out_valid && out_ready && sz != 0) begin
                if (out_data != model[0])
                    report_error($sformatf("out_data %h, expected %h", out_data, model[0]));
                do_pop = 1'b1;
            end
            if (in_valid && in_ready) begin
                do_push  = 1'b1;
                push_val = in_data;
            end
            if (do_flush) begin
                model.delete();
            end else begin
                if (do_pop) void'(model.pop_front());
                if (do_push) model.push_back(push_val);
            end
        end
    end

    initial begin
        logic [31:0] v;
        logic [1:0]  r;
        rst_n     = 1'b0;
        awaddr    = '0;
        awvalid   = '0;
        wdata     = '0;
        wvalid    = '0;
        bready    = '0;
        araddr    = '0;
        arvalid   = '0;
        rready    = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        if (awready != 0 || wready != 0 || arready != 0 || bvalid != 0 || rvalid != 0)
            report_error("bus ready or valid outputs not low after reset");
        if (!in_ready || out_valid) report_error("stream handshake wrong after reset");
        bus_read(0, `REG_STATUS, v, r);
        if (v != 32'h1) report_error($sformatf("STATUS after reset %h, expected 1", v));
        bus_read(1, `REG_COUNT, v, r);
        if (v != 0) report_error($sformatf("COUNT after reset %0d, expected 0", v));
        end_test("after reset");

        fork
            repeat (RAND_OPS) random_op(0);
            repeat (RAND_OPS) random_op(1);
        join
        end_test("random traffic");

        bus_write(0, `REG_CONTROL, 32'h1, r);
        for (int i = 0; i < DEPTH; i++) bus_write(i % 2, `REG_DATA, $random(seed), r);
        bus_write(1, `REG_DATA, 32'hdead_beef, r);
        if (r != SLVERR) report_error("push into full FIFO not answered with SLVERR");
        bus_read(0, `REG_COUNT, v, r);
        if (v != DEPTH) report_error($sformatf("COUNT after overflow %0d, expected 16", v));
        bus_write(0, `REG_STATUS, 32'h0, r);
        if (r != SLVERR) report_error("write to STATUS accepted");
        bus_write(1, `REG_COUNT, 32'h0, r);
        if (r != SLVERR) report_error("write to COUNT accepted");
        bus_write(0, 4'h2, 32'h0, r);
        if (r != SLVERR) report_error("write to unmapped address accepted");
        bus_read(1, 4'h6, v, r);
        if (v != 0 || r != SLVERR) report_error("unmapped read not zero with SLVERR");
        end_test("overflow and illegal access");

        repeat (30) begin
            random_op($unsigned($random(seed)) % 2);
            bus_read(0, `REG_STATUS, v, r);
            bus_read(1, `REG_COUNT, v, r);
        end
        end_test("status and count");

        repeat (3) bus_write(0, `REG_DATA, $random(seed), r);
        bus_write(1, `REG_CONTROL, 32'h1, r);
        bus_read(0, `REG_COUNT, v, r);
        if (v != 0) report_error($sformatf("COUNT after flush %0d, expected 0", v));
        bus_read(1, `REG_STATUS, v, r);
        if (v != 32'h1) report_error($sformatf("STATUS after flush %h, expected 1", v));
        if (out_valid) report_error("out_valid high after flush");
        end_test("flush");

        fork
            drive_stream(STREAM_CYCLES);
            repeat (MIX_OPS) random_op(0);
            repeat (MIX_OPS) random_op(1);
        join
        end_test("stream traffic");

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
logic/fifo_mm_pkg.sv
logic/axil_rr_arbiter.sv
logic/fifo_store.sv
logic/fifo_csr.sv
logic/fifo_mm_top.sv
dv/fifo_mm_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 --top-module fifo_mm_tb -f compile.f -o fifo_mm_sim \
    && ./obj_dir/fifo_mm_sim > sim.log 2>&1 \
    || echo "Build or simulation did not complete" >> sim.log

cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || grep -q "TEST PASS" sim.log
